// File: src/decodePkg.sv
package decodePkg;

    localparam int dataWidth   = 32;
    localparam int addrWidth   = 32;
    localparam int regIdxWidth = 5;
    localparam int numRegs     = 32;

    typedef logic [dataWidth-1:0]   data_t;
    typedef logic [addrWidth-1:0]   addr_t;
    typedef logic [regIdxWidth-1:0] regIdx_t;

    // Immediate layouts
    typedef enum logic [2:0] {
        fmtNone,
        fmtI,
        fmtS,
        fmtB,
        fmtU,
        fmtJ,
        fmtShift    // shamt only, zero-extended
    } immFmt_t;

endpackage

// File: src/rvIsaPkg.sv
package rvIsaPkg;

    // Major opcodes, inst[6:0]
    localparam logic [6:0] opLui    = 7'b0110111;
    localparam logic [6:0] opAuipc  = 7'b0010111;
    localparam logic [6:0] opJal    = 7'b1101111;
    localparam logic [6:0] opJalr   = 7'b1100111;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opRegImm = 7'b0010011;
    localparam logic [6:0] opRegReg = 7'b0110011;

    // funct3, inst[14:12]
    localparam logic [2:0] f3Jalr = 3'b000;
    localparam logic [2:0] f3Beq  = 3'b000;
    localparam logic [2:0] f3Bne  = 3'b001;
    localparam logic [2:0] f3Blt  = 3'b100;
    localparam logic [2:0] f3Bge  = 3'b101;
    localparam logic [2:0] f3Bltu = 3'b110;
    localparam logic [2:0] f3Bgeu = 3'b111;
    localparam logic [2:0] f3Lb   = 3'b000;
    localparam logic [2:0] f3Lh   = 3'b001;
    localparam logic [2:0] f3Lw   = 3'b010;
    localparam logic [2:0] f3Lbu  = 3'b100;
    localparam logic [2:0] f3Lhu  = 3'b101;
    localparam logic [2:0] f3Sb   = 3'b000;
    localparam logic [2:0] f3Sh   = 3'b001;
    localparam logic [2:0] f3Sw   = 3'b010;
    localparam logic [2:0] f3Add  = 3'b000;     // Also SUB
    localparam logic [2:0] f3Sll  = 3'b001;
    localparam logic [2:0] f3Slt  = 3'b010;
    localparam logic [2:0] f3Sltu = 3'b011;
    localparam logic [2:0] f3Xor  = 3'b100;
    localparam logic [2:0] f3Srl  = 3'b101;     // Also SRA
    localparam logic [2:0] f3Or   = 3'b110;
    localparam logic [2:0] f3And  = 3'b111;

    // funct7 bit 5 sits at inst[30], selects SUB and SRA/SRAI
    localparam int f7AltBit = 30;

    typedef enum logic [5:0] {
        idNop,
        idLui, idAuipc, idJal, idJalr,
        idBeq, idBne, idBlt, idBge, idBltu, idBgeu,
        idLb, idLh, idLw, idLbu, idLhu,
        idSb, idSh, idSw,
        idAddi, idSlti, idSltiu, idXori, idOri, idAndi, idSlli, idSrli, idSrai,
        idAdd, idSub, idSll, idSlt, idSltu, idXor, idSrl, idSra, idOr, idAnd
    } instIdx_t;

    function automatic logic isLoad(instIdx_t id);
        return id inside {idLb, idLh, idLw, idLbu, idLhu};
    endfunction

endpackage

// File: src/instDecoder.sv
module instDecoder (
    input  logic [31:0]         inst,
    output rvIsaPkg::instIdx_t  instIdx,
    output logic                instLegal,
    output decodePkg::immFmt_t  immFmt,
    output logic                rs1En,
    output logic                rs2En,
    output logic                rdEn,
    output decodePkg::regIdx_t  rs1Idx,
    output decodePkg::regIdx_t  rs2Idx,
    output decodePkg::regIdx_t  rdIdx
);
    import decodePkg::*;
    import rvIsaPkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       alt;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign alt    = inst[f7AltBit];

    always_comb begin
        instIdx = idNop;
        immFmt  = fmtNone;
        rs1En   = 1'b0;
        rs2En   = 1'b0;
        rdEn    = 1'b0;
        case (opcode)
            opLui: begin
                instIdx = idLui;
                immFmt  = fmtU;
                rdEn    = 1'b1;
            end
            opAuipc: begin
                instIdx = idAuipc;
                immFmt  = fmtU;
                rdEn    = 1'b1;
            end
            opJal: begin
                instIdx = idJal;
                immFmt  = fmtJ;
                rdEn    = 1'b1;
            end
            opJalr: begin
                instIdx = (funct3 == f3Jalr) ? idJalr : idNop;
                immFmt  = fmtI;
                rs1En   = 1'b1;
                rdEn    = 1'b1;
            end
            opBranch: begin
                immFmt = fmtB;
                rs1En  = 1'b1;
                rs2En  = 1'b1;
                case (funct3)
                    f3Beq:   instIdx = idBeq;
                    f3Bne:   instIdx = idBne;
                    f3Blt:   instIdx = idBlt;
                    f3Bge:   instIdx = idBge;
                    f3Bltu:  instIdx = idBltu;
                    f3Bgeu:  instIdx = idBgeu;
                    default: instIdx = idNop;
                endcase
            end
            opLoad: begin
                immFmt = fmtI;
                rs1En  = 1'b1;
                rdEn   = 1'b1;
                case (funct3)
                    f3Lb:    instIdx = idLb;
                    f3Lh:    instIdx = idLh;
                    f3Lw:    instIdx = idLw;
                    f3Lbu:   instIdx = idLbu;
                    f3Lhu:   instIdx = idLhu;
                    default: instIdx = idNop;
                endcase
            end
            opStore: begin
                immFmt = fmtS;
                rs1En  = 1'b1;
                rs2En  = 1'b1;
                case (funct3)
                    f3Sb:    instIdx = idSb;
                    f3Sh:    instIdx = idSh;
                    f3Sw:    instIdx = idSw;
                    default: instIdx = idNop;
                endcase
            end
            opRegImm: begin
                immFmt = fmtI;
                rs1En  = 1'b1;
                rdEn   = 1'b1;
                case (funct3)
                    f3Add:   instIdx = idAddi;
                    f3Slt:   instIdx = idSlti;
                    f3Sltu:  instIdx = idSltiu;
                    f3Xor:   instIdx = idXori;
                    f3Or:    instIdx = idOri;
                    f3And:   instIdx = idAndi;
                    f3Sll:   begin
                        instIdx = idSlli;
                        immFmt  = fmtShift;
                    end
                    default: begin                                  // SRLI / SRAI
                        instIdx = alt ? idSrai : idSrli;
                        immFmt  = fmtShift;
                    end
                endcase
            end
            opRegReg: begin
                rs1En = 1'b1;
                rs2En = 1'b1;
                rdEn  = 1'b1;
                case (funct3)
                    f3Add:   instIdx = alt ? idSub : idAdd;
                    f3Sll:   instIdx = idSll;
                    f3Slt:   instIdx = idSlt;
                    f3Sltu:  instIdx = idSltu;
                    f3Xor:   instIdx = idXor;
                    f3Srl:   instIdx = alt ? idSra : idSrl;
                    f3Or:    instIdx = idOr;
                    default: instIdx = idAnd;
                endcase
            end
            default: instIdx = idNop;
        endcase
        if (instIdx == idNop) begin                                 // Illegal clears everything
            immFmt = fmtNone;
            rs1En  = 1'b0;
            rs2En  = 1'b0;
            rdEn   = 1'b0;
        end
    end

    assign instLegal = (instIdx != idNop);
    assign rs1Idx    = rs1En ? inst[19:15] : '0;
    assign rs2Idx    = rs2En ? inst[24:20] : '0;
    assign rdIdx     = rdEn  ? inst[11:7]  : '0;

endmodule

// File: src/immGen.sv
module immGen (
    input  logic [31:0]         inst,
    input  decodePkg::immFmt_t  immFmt,
    output decodePkg::data_t    immData
);
    import decodePkg::*;

    always_comb begin
        case (immFmt)
            fmtI: begin
                immData = data_t'($signed(inst[31:20]));
            end
            fmtS: begin
                immData = data_t'($signed({inst[31:25], inst[11:7]}));
            end
            fmtB: begin
                immData = data_t'($signed({inst[31], inst[7], inst[30:25],
                                           inst[11:8], 1'b0}));
            end
            fmtU: begin
                immData = data_t'({inst[31:12], 12'b0});            // Low 12 bits zero
            end
            fmtJ: begin
                immData = data_t'($signed({inst[31], inst[19:12], inst[20],
                                           inst[30:21], 1'b0}));
            end
            fmtShift: begin
                immData = data_t'(inst[24:20]);                     // shamt
            end
            default: begin
                immData = '0;
            end
        endcase
    end

endmodule

// File: src/operandSelect.sv
module operandSelect (
    input  logic                srcEn,
    input  decodePkg::regIdx_t  srcIdx,

    input  logic                exRdEn,
    input  decodePkg::regIdx_t  exRdIdx,
    input  decodePkg::data_t    exRdData,
    input  logic                exIsLoad,

    input  logic                memRdEn,
    input  decodePkg::regIdx_t  memRdIdx,
    input  decodePkg::data_t    memRdData,

    input  decodePkg::data_t    regData,

    output decodePkg::data_t    operand,
    output logic                hazard
);

    logic exHit;
    logic memHit;

    // x0 and disabled writers never match
    assign exHit  = exRdEn  && (exRdIdx  != '0) && (exRdIdx  == srcIdx);
    assign memHit = memRdEn && (memRdIdx != '0) && (memRdIdx == srcIdx);

    always_comb begin
        operand = '0;
        hazard  = 1'b0;
        if (!srcEn) begin
            operand = '0;
        end else if (exHit && exIsLoad) begin
            hazard = 1'b1;                                          // Load data not ready yet
        end else if (exHit) begin
            operand = exRdData;
        end else if (memHit) begin
            operand = memRdData;
        end else begin
            operand = regData;
        end
    end

endmodule

// File: src/regFile.sv
module regFile (
    input  logic                clk,
    input  logic                rst,
    input  decodePkg::regIdx_t  rdIdxA,
    input  decodePkg::regIdx_t  rdIdxB,
    input  logic                wrEn,
    input  decodePkg::regIdx_t  wrIdx,
    input  decodePkg::data_t    wrData,
    output decodePkg::data_t    rdDataA,
    output decodePkg::data_t    rdDataB
);
    import decodePkg::*;

    data_t regs [numRegs];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && (wrIdx != '0)) begin
            regs[wrIdx] <= wrData;
        end
    end

    // x0 reads zero, same-cycle write is bypassed
    assign rdDataA = (rdIdxA == '0)                 ? '0     :
                     (wrEn && (wrIdx == rdIdxA))    ? wrData : regs[rdIdxA];
    assign rdDataB = (rdIdxB == '0)                 ? '0     :
                     (wrEn && (wrIdx == rdIdxB))    ? wrData : regs[rdIdxB];

endmodule

// File: src/decodeStage.sv
module decodeStage (
    input  logic                clk,
    input  logic                rst,
    input  logic                inValid,
    input  decodePkg::addr_t    pc,
    input  logic [31:0]         inst,
    input  logic                exRdEn,
    input  decodePkg::regIdx_t  exRdIdx,
    input  decodePkg::data_t    exRdData,
    input  rvIsaPkg::instIdx_t  exInstIdx,
    input  logic                memRdEn,        // Non-memory MEM result only
    input  decodePkg::regIdx_t  memRdIdx,
    input  decodePkg::data_t    memRdData,
    input  logic                wbEn,
    input  decodePkg::regIdx_t  wbIdx,
    input  decodePkg::data_t    wbData,
    output logic                stall,
    output logic                outValid,
    output decodePkg::addr_t    outPc,
    output rvIsaPkg::instIdx_t  outInstIdx,
    output logic                outInstLegal,
    output logic                outRdEn,
    output decodePkg::regIdx_t  outRdIdx,
    output decodePkg::data_t    outRs1Data,
    output decodePkg::data_t    outRs2Data,
    output decodePkg::data_t    outImmData
);
    import decodePkg::*;
    import rvIsaPkg::*;

    instIdx_t instIdx;
    immFmt_t  immFmt;
    logic     instLegal, rs1En, rs2En, rdEn;
    regIdx_t  rs1Idx, rs2Idx, rdIdx;
    data_t    immData, rs1Reg, rs2Reg, rs1Data, rs2Data;
    logic     rs1Hazard, rs2Hazard, exIsLoad, accept;

    assign exIsLoad = isLoad(exInstIdx);
    assign stall    = inValid && (rs1Hazard || rs2Hazard);
    assign accept   = inValid && !stall;

    instDecoder i_decoder (.*);

    immGen i_immGen (.*);

    regFile i_regFile (
        .clk(clk), .rst(rst),
        .rdIdxA(rs1Idx), .rdIdxB(rs2Idx),
        .wrEn(wbEn), .wrIdx(wbIdx), .wrData(wbData),
        .rdDataA(rs1Reg), .rdDataB(rs2Reg)
    );

    operandSelect i_rs1Sel (
        .srcEn(rs1En), .srcIdx(rs1Idx), .regData(rs1Reg),
        .operand(rs1Data), .hazard(rs1Hazard), .*
    );

    operandSelect i_rs2Sel (
        .srcEn(rs2En), .srcIdx(rs2Idx), .regData(rs2Reg),
        .operand(rs2Data), .hazard(rs2Hazard), .*
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            outValid     <= 1'b0;
            outPc        <= '0;
            outInstIdx   <= idNop;
            outInstLegal <= 1'b0;
            outRdEn      <= 1'b0;
            outRdIdx     <= '0;
            outRs1Data   <= '0;
            outRs2Data   <= '0;
            outImmData   <= '0;
        end else begin
            outValid <= accept;                                     // One-cycle strobe
            if (accept) begin
                outPc        <= pc;
                outInstIdx   <= instIdx;
                outInstLegal <= instLegal;
                outRdEn      <= rdEn;
                outRdIdx     <= rdIdx;
                outRs1Data   <= rs1Data;
                outRs2Data   <= rs2Data;
                outImmData   <= immData;
            end
        end
    end

endmodule

// File: test/decodeModel.svh
`ifndef DECODEMODEL_SVH
`define DECODEMODEL_SVH

// Identifier per funct3 for each opcode group
localparam instIdx_t branchIds [8] = '{idBeq, idBne, idNop, idNop, idBlt, idBge, idBltu, idBgeu};
localparam instIdx_t loadIds [8]   = '{idLb, idLh, idLw, idNop, idLbu, idLhu, idNop, idNop};
localparam instIdx_t storeIds [8]  = '{idSb, idSh, idSw, idNop, idNop, idNop, idNop, idNop};
localparam instIdx_t regImmIds [8] = '{idAddi, idSlli, idSlti, idSltiu,
                                       idXori, idSrli, idOri, idAndi};
localparam instIdx_t regRegIds [8] = '{idAdd, idSll, idSlt, idSltu, idXor, idSrl, idOr, idAnd};

logic [31:0] shadowRegs [32];                       // Architectural register state
logic        expStall;
logic        expValid;
logic [31:0] expPc;
instIdx_t    expIdx;
logic        expLegal;
logic        expRdEn;
logic [4:0]  expRdIdx;
logic [31:0] expRs1;
logic [31:0] expRs2;
logic [31:0] expImm;

task automatic resetModel();
    foreach (shadowRegs[i])
        shadowRegs[i] = '0;
    expStall = 1'b0;
    expValid = 1'b0;
    expPc    = '0;
    expIdx   = idNop;
    expLegal = 1'b0;
    expRdEn  = 1'b0;
    expRdIdx = '0;
    expRs1   = '0;
    expRs2   = '0;
    expImm   = '0;
endtask

function automatic logic isLoadInst(instIdx_t id);
    return (id == idLb) || (id == idLh) || (id == idLw) || (id == idLbu) || (id == idLhu);
endfunction

function automatic void decodeWord(input logic [31:0] w, output instIdx_t id,
                                   output logic use1, output logic use2,
                                   output logic wrRd, output logic [31:0] imm);
    logic [6:0]  op;
    logic [2:0]  f3;
    logic        legal;
    logic [31:0] immI;
    logic [31:0] immS;
    logic [31:0] immB;
    logic [31:0] immU;
    logic [31:0] immJ;
    logic [31:0] immSh;
    op    = w[6:0];
    f3    = w[14:12];
    immI  = {{20{w[31]}}, w[31:20]};
    immS  = {{20{w[31]}}, w[31:25], w[11:7]};
    immB  = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    immU  = {w[31:12], 12'h000};
    immJ  = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    immSh = {27'd0, w[24:20]};
    case (op)
        7'b0110111: id = idLui;
        7'b0010111: id = idAuipc;
        7'b1101111: id = idJal;
        7'b1100111: id = (f3 == 3'd0) ? idJalr : idNop;
        7'b1100011: id = branchIds[f3];
        7'b0000011: id = loadIds[f3];
        7'b0100011: id = storeIds[f3];
        7'b0010011: id = (f3 == 3'd5 && w[30]) ? idSrai : regImmIds[f3];
        7'b0110011: id = (w[30] && f3 == 3'd0) ? idSub :
                         (w[30] && f3 == 3'd5) ? idSra : regRegIds[f3];
        default:    id = idNop;
    endcase
    legal = (id != idNop);
    use1  = legal && op != 7'b0110111 && op != 7'b0010111 && op != 7'b1101111;
    use2  = legal && (op == 7'b1100011 || op == 7'b0100011 || op == 7'b0110011);
    wrRd  = legal && op != 7'b1100011 && op != 7'b0100011;
    case (op)
        7'b0110111, 7'b0010111: imm = immU;
        7'b1101111:             imm = immJ;
        7'b1100011:             imm = immB;
        7'b0100011:             imm = immS;
        7'b0010011:             imm = (f3 == 3'd1 || f3 == 3'd5) ? immSh : immI;
        7'b0110011:             imm = '0;
        default:                imm = immI;         // JALR and loads
    endcase
    if (!legal)
        imm = '0;
endfunction

// One source operand with EX over MEM over register state
function automatic void selectOperand(input logic en, input logic [4:0] idx, input logic exLoad,
                                      output logic [31:0] val, output logic haz);
    logic exMatch;
    logic memMatch;
    exMatch  = exRdEn && (exRdIdx != 5'd0) && (exRdIdx == idx);
    memMatch = memRdEn && (memRdIdx != 5'd0) && (memRdIdx == idx);
    haz      = en && exMatch && exLoad;
    if (!en || haz)
        val = '0;
    else if (exMatch)
        val = exRdData;
    else if (memMatch)
        val = memRdData;
    else if (idx == 5'd0)
        val = '0;
    else if (wbEn && wbIdx == idx)
        val = wbData;                               // Same-cycle writeback
    else
        val = shadowRegs[idx];
endfunction

`endif

// File: test/tbDecode.sv
module tbDecode;
    timeunit 1ns;
    timeprecision 1ps;
    import decodePkg::*;
    import rvIsaPkg::*;

    localparam int numCycles     = 2000;
    localparam int timeoutCycles = numCycles + 100;     // Reset and drain fit well inside
    localparam logic [6:0] legalOps [9] = '{opLui, opAuipc, opJal, opJalr, opBranch,
                                            opLoad, opStore, opRegImm, opRegReg};

    logic        clk;
    logic        rst;
    logic        inValid;
    addr_t       pc;
    logic [31:0] inst;
    logic        exRdEn;
    regIdx_t     exRdIdx;
    data_t       exRdData;
    instIdx_t    exInstIdx;
    logic        memRdEn;
    regIdx_t     memRdIdx;
    data_t       memRdData;
    logic        wbEn;
    regIdx_t     wbIdx;
    data_t       wbData;
    logic        stall;
    logic        outValid;
    addr_t       outPc;
    instIdx_t    outInstIdx;
    logic        outInstLegal;
    logic        outRdEn;
    regIdx_t     outRdIdx;
    data_t       outRs1Data;
    data_t       outRs2Data;
    data_t       outImmData;

    int errCount   = 0;
    int checkCount = 0;
    int cycleCount = 0;

    `include "decodeModel.svh"

    decodeStage i_dut (.*);

    always #20 clk = ~clk;

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        checkCount++;
        if (actual !== expected) begin
            errCount++;
            $display("** Error at %0d ns: %s is %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic driveInputs();
        logic [31:0] word;
        logic [4:0]  srcPick [3];
        word = inst;
        if (!expStall) begin                                // Upstream holds while stalled
            word = $urandom();
            if ($urandom_range(1, 0) == 1)
                word[6:0] = legalOps[4'($urandom_range(8, 0))];
            inValid <= ($urandom_range(9, 0) < 7);
            pc      <= $urandom() & 32'hFFFF_FFFC;
            inst    <= word;
        end
        srcPick[0] = word[19:15];                           // Bias writers onto the sources
        srcPick[1] = word[24:20];
        srcPick[2] = 5'($urandom());
        exRdEn    <= 1'($urandom());
        exRdIdx   <= srcPick[2'($urandom_range(2, 0))];
        exRdData  <= $urandom();
        exInstIdx <= ($urandom_range(3, 0) == 0) ? idLw : instIdx_t'(6'($urandom_range(37, 0)));
        memRdEn   <= 1'($urandom());
        memRdIdx  <= srcPick[2'($urandom_range(2, 0))];
        memRdData <= $urandom();
        wbEn      <= 1'($urandom());
        wbIdx     <= srcPick[2'($urandom_range(2, 0))];
        wbData    <= $urandom();
    endtask

    task automatic compareOutputs();
        checkValue("outValid", 32'(outValid), 32'(expValid));
        checkValue("outPc", outPc, expPc);
        checkValue("outInstIdx", 32'(outInstIdx), 32'(expIdx));
        checkValue("outInstLegal", 32'(outInstLegal), 32'(expLegal));
        checkValue("outRdEn", 32'(outRdEn), 32'(expRdEn));
        checkValue("outRdIdx", 32'(outRdIdx), 32'(expRdIdx));
        checkValue("outRs1Data", outRs1Data, expRs1);
        checkValue("outRs2Data", outRs2Data, expRs2);
        checkValue("outImmData", outImmData, expImm);
    endtask

    task automatic predictCycle();
        instIdx_t    id;
        logic        use1;
        logic        use2;
        logic        wrRd;
        logic [31:0] imm;
        logic [31:0] op1;
        logic [31:0] op2;
        logic        haz1;
        logic        haz2;
        logic        exLoad;
        decodeWord(inst, id, use1, use2, wrRd, imm);
        exLoad = isLoadInst(exInstIdx);
        selectOperand(use1, use1 ? inst[19:15] : 5'd0, exLoad, op1, haz1);
        selectOperand(use2, use2 ? inst[24:20] : 5'd0, exLoad, op2, haz2);
        expStall = inValid && (haz1 || haz2);
        checkValue("stall", 32'(stall), 32'(expStall));
        expValid = inValid && !expStall;
        if (expValid) begin                                 // Captured at the next edge
            expPc    = pc;
            expIdx   = id;
            expLegal = (id != idNop);
            expRdEn  = wrRd;
            expRdIdx = wrRd ? inst[11:7] : 5'd0;
            expRs1   = op1;
            expRs2   = op2;
            expImm   = imm;
        end
        if (wbEn && wbIdx != 5'd0)
            shadowRegs[wbIdx] = wbData;
    endtask

    // Inputs are stable between the falling edge and the next rising edge
    always @(negedge clk) begin
        if (rst) begin
            resetModel();
        end else begin
            compareOutputs();
            predictCycle();
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= timeoutCycles) begin
            $display("Timeout: the run did not finish within %0d cycles", timeoutCycles);
            $display("** FAIL **");
            $finish;
        end
    end

    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        inValid   = 1'b0;
        pc        = '0;
        inst      = '0;
        exRdEn    = 1'b0;
        exRdIdx   = '0;
        exRdData  = '0;
        exInstIdx = idNop;
        memRdEn   = 1'b0;
        memRdIdx  = '0;
        memRdData = '0;
        wbEn      = 1'b0;
        wbIdx     = '0;
        wbData    = '0;
        resetModel();
        void'($urandom(13657));
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        repeat (numCycles) begin
            @(posedge clk);
            driveInputs();
        end
        @(posedge clk);
        inValid <= 1'b0;
        repeat (2) @(posedge clk);                          // Let the last capture be checked
        $display("Decode run done: %0d checks, %0d errors", checkCount, errCount);
        if (errCount == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+test
src/decodePkg.sv
src/rvIsaPkg.sv
src/instDecoder.sv
src/immGen.sv
src/operandSelect.sv
src/regFile.sv
src/decodeStage.sv
test/tbDecode.sv

// File: run.sh
#!/bin/sh
verilator --binary --timing --timescale 1ns/1ps --top-module tbDecode \
    -f verilog.f -o simDecode \
    && ./obj_dir/simDecode > sim.log 2>&1 \
    && cat sim.log \
    && grep -qx '\*\* PASS \*\*' sim.log \
    && echo "Simulation passed" \
    || { cat sim.log 2>/dev/null; echo "Simulation failed"; exit 1; }
